/* sources.f */
+incdir+verif
design/decode_pkg.sv
design/pipe_reg.sv
design/regfile.sv
design/instr_decoder.sv
design/operand_bypass.sv
design/branch_unit.sv
design/decode_stage.sv
verif/decode_props.sv
verif/tb_decode.sv

/* Makefile */
# Verilator build and run of the decode stage testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the simulation, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_decode -f sources.f
	./obj_dir/Vtb_decode +verilator+error+limit+100 > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@if grep -q "Result: FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* verif/decode_model.svh */
issue_t exp_issue;    // expected issue_o in the current cycle
jump_t  exp_jump;
logic   exp_ready;
issue_t nxt_issue;    // what the edge at the end of the cycle should load
jump_t  nxt_jump;
word_t  shadow [32];  // entry 0 is never written

task automatic model_reset();
    exp_issue = NOP_ISSUE;
    exp_jump  = '0;
    exp_ready = 1'b1;
    shadow    = '{default: '0};
endtask

function automatic logic hits(input fwd_t src, input regaddr_t a);
    return src.valid && src.addr == a;
endfunction

// youngest producer first, register file last
function automatic word_t operand(input regaddr_t a, output logic stall);
    fwd_t id_src;
    id_src = '{valid: exp_issue.wb_valid, ready: exp_issue.wb_ready,
               addr: exp_issue.wb_addr, data: exp_issue.wb_data};
    stall = (hits(id_src, a) && !id_src.ready)
         || (hits(ex_fwd_i, a) && !ex_fwd_i.ready)
         || (hits(ma_fwd_i, a) && !ma_fwd_i.ready);
    if (hits(id_src, a)) return id_src.data;
    if (hits(ex_fwd_i, a)) return ex_fwd_i.data;
    if (hits(ma_fwd_i, a)) return ma_fwd_i.data;
    if (hits(wb_fwd_i, a)) return wb_fwd_i.data;
    return shadow[a];
endfunction

function automatic alu_mode_t alu_for(input logic [2:0] f3, input logic alt);
    case (f3)
        F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
        F3_SLL:     return ALU_SLL;
        F3_SLT:     return ALU_SLT;
        F3_SLTU:    return ALU_SLTU;
        F3_XOR:     return ALU_XOR;
        F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
        F3_OR:      return ALU_OR;
        default:    return ALU_AND;
    endcase
endfunction

// eq, lt, ltu chosen by funct3[2:1], bit 0 inverts
function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    logic c;
    case (f3[2:1])
        2'b00:   c = (a == b);
        2'b10:   c = ($signed(a) < $signed(b));
        2'b11:   c = (a < b);
        default: c = 1'b0;
    endcase
    return c ^ f3[0];
endfunction

task automatic model_eval();
    logic [2:0] f3;
    word_t      ra, rb, imm_i, imm_s, imm_b, imm_u, imm_j, target;
    logic       stall_a, stall_b, use_a, use_b, take, active, hazard;
    issue_t     w;

    f3    = ir_i[14:12];
    imm_i = $signed(ir_i) >>> 20;
    imm_s = $signed({ir_i[31:25], ir_i[11:7], 20'b0}) >>> 20;
    imm_b = $signed({ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 20'b0}) >>> 19;
    imm_u = {ir_i[31:12], 12'b0};
    imm_j = $signed({ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 12'b0}) >>> 11;
    ra    = operand(ir_i[19:15], stall_a);
    rb    = operand(ir_i[24:20], stall_b);

    w         = NOP_ISSUE;
    w.valid   = 1'b1;
    w.pc      = pc_i;
    w.ir      = ir_i;
    w.ma_data = rb;
    w.wb_addr = ir_i[11:7];
    w.wb_data = pc_i + 32'd4;
    use_a     = 1'b0;
    use_b     = 1'b0;
    take      = 1'b0;
    target    = '0;

    case (ir_i[6:0])
        OPC_OP: begin
            w.alu_op1  = ra;
            w.alu_op2  = rb;
            w.alu_mode = alu_for(f3, ir_i[30]);
            w.wb_valid = 1'b1;
            use_a      = 1'b1;
            use_b      = 1'b1;
        end
        OPC_OP_IMM: begin
            w.alu_op1  = ra;
            w.alu_op2  = imm_i;
            w.alu_mode = alu_for(f3, ir_i[30] && f3 == F3_SRL_SRA);  // srai only
            w.wb_valid = 1'b1;
            use_a      = 1'b1;
        end
        OPC_LUI: begin
            w.alu_op1  = imm_u;
            w.wb_valid = 1'b1;
        end
        OPC_AUIPC: begin
            w.alu_op1  = imm_u;
            w.alu_op2  = pc_i;
            w.wb_valid = 1'b1;
        end
        OPC_JAL: begin
            w.wb_src   = WB_PC4;
            w.wb_valid = 1'b1;
            take       = 1'b1;
            target     = pc_i + imm_j;
        end
        OPC_JALR: begin
            w.wb_src   = WB_PC4;
            w.wb_valid = 1'b1;
            use_a      = 1'b1;
            take       = 1'b1;
            target     = ra + imm_i;
        end
        OPC_BRANCH: begin
            use_a  = 1'b1;
            use_b  = 1'b1;
            take   = branch_taken(f3, ra, rb);
            target = pc_i + imm_b;
        end
        OPC_LOAD: begin
            w.alu_op1  = ra;
            w.alu_op2  = imm_i;
            w.ma_mode  = MA_LOAD;
            w.ma_size  = f3;
            w.wb_src   = WB_MEM;
            w.wb_valid = 1'b1;
            use_a      = 1'b1;
        end
        OPC_STORE: begin
            w.alu_op1 = ra;
            w.alu_op2 = imm_s;
            w.ma_mode = MA_STORE;
            w.ma_size = f3;
            use_a     = 1'b1;
            use_b     = 1'b1;
        end
        default: ;
    endcase

    w.wb_ready     = (w.wb_src == WB_PC4);
    active         = in_valid_i && !exp_jump.valid;  // squashed behind a jump
    hazard         = active && ((use_a && stall_a) || (use_b && stall_b));
    exp_ready      = !hazard;
    nxt_issue      = (active && !hazard) ? w : NOP_ISSUE;
    nxt_jump.valid = active && !hazard && take;
    nxt_jump.addr  = nxt_jump.valid ? target : '0;
endtask

task automatic model_commit();
    exp_issue = nxt_issue;
    exp_jump  = nxt_jump;
    if (wb_fwd_i.valid && wb_fwd_i.addr != '0) begin
        shadow[wb_fwd_i.addr] = wb_fwd_i.data;
    end
endtask

/* verif/tb_decode.sv */
`timescale 1ns/1ps

module tb_decode;

    import decode_pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int T_RESET      = 0;
    localparam int T_ALU        = 1;
    localparam int T_BYPASS     = 2;
    localparam int T_HAZARD     = 3;
    localparam int T_JUMP       = 4;
    localparam int T_MEM        = 5;
    localparam int N_RESET      = 40;  // first 31 cycles fill the register file
    localparam int N_TEST       = 400;
    localparam int MAX_CYCLES   = RESET_CYCLES + N_RESET + 5 * N_TEST + 50;

    logic   clk_i;
    logic   rst_n_i;
    logic   in_valid_i;
    word_t  pc_i;
    word_t  ir_i;
    logic   ready_o;
    fwd_t   ex_fwd_i;
    fwd_t   ma_fwd_i;
    fwd_t   wb_fwd_i;
    issue_t issue_o;
    jump_t  jump_o;

    logic [31:0] lfsr = 32'h64ceb3f3;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    `include "decode_model.svh"

    decode_stage DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // galois lfsr, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [6:0] pick_opcode(input int test);
        logic [6:0] set [4];
        case (test)
            T_ALU:    set = '{OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC};
            T_BYPASS: set = '{OPC_OP, OPC_OP, OPC_OP_IMM, OPC_STORE};
            T_HAZARD: set = '{OPC_OP, OPC_LOAD, OPC_BRANCH, OPC_JALR};
            T_JUMP:   set = '{OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_OP_IMM};
            default:  set = '{OPC_LOAD, OPC_STORE, OPC_LOAD, OPC_OP};
        endcase
        if (test == T_ALU && rand_bits(3) == 0) begin
            return 7'(rand_bits(7));  // mostly unsupported opcodes
        end
        return set[2'(rand_bits(2))];
    endfunction

    // register fields from a small range so sources collide often
    function automatic word_t make_instr(input int test, input int abits);
        word_t ir;
        ir        = rand_bits(32);
        ir[6:0]   = pick_opcode(test);
        ir[11:7]  = 5'(rand_bits(abits));
        ir[19:15] = 5'(rand_bits(abits));
        ir[24:20] = 5'(rand_bits(abits));
        return ir;
    endfunction

    function automatic fwd_t make_fwd(input int abits, input int rbits);
        fwd_t f;
        f.addr  = 5'(rand_bits(abits));
        f.valid = (rand_bits(1) != 0) && f.addr != '0;
        f.ready = (rbits == 0) || (rand_bits(rbits) != 0);
        f.data  = rand_bits(32);
        return f;
    endfunction

    task automatic log_error(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    // inputs are already driven, check mid cycle then advance the model
    task automatic step();
        @(negedge clk_i);
        model_eval();
        checks += 3;
        assert (ready_o === exp_ready)
            else log_error($sformatf("ready_o %b, expected %b", ready_o, exp_ready));
        assert (issue_o === exp_issue)
            else log_error($sformatf("issue_o %h, expected %h", issue_o, exp_issue));
        assert (jump_o === exp_jump)
            else log_error($sformatf("jump_o %h, expected %h", jump_o, exp_jump));
        @(posedge clk_i);
        model_commit();
        #1;
    endtask

    task automatic run_test(input string name, input int test, input int n);
        int first_error;
        int abits;
        int rbits;
        first_error = errors;
        abits       = (test == T_BYPASS) ? 2 : 3;
        rbits       = (test == T_HAZARD) ? 1 : ((test == T_BYPASS) ? 0 : 3);
        for (int i = 0; i < n; i++) begin
            if (test == T_RESET) begin
                checks++;
                assert (!issue_o.valid && !jump_o.valid)
                    else log_error("issue or jump valid with no accepted instruction");
                in_valid_i = 1'b0;
                wb_fwd_i   = '{valid: (i < 31), ready: 1'b1, addr: 5'(i + 1),
                               data: rand_bits(32)};
            end else begin
                in_valid_i = (rand_bits(3) != 0);
                pc_i       = rand_bits(30) << 2;
                ir_i       = make_instr(test, abits);
                ex_fwd_i   = make_fwd(abits, rbits);
                ma_fwd_i   = make_fwd(abits, rbits);
                wb_fwd_i   = make_fwd(abits, rbits);
            end
            step();
        end
        $display("test %s: %0d cycles, %0d errors", name, n, errors - first_error);
    endtask

    initial begin
        rst_n_i    = 1'b0;
        in_valid_i = 1'b0;
        pc_i       = '0;
        ir_i       = '0;
        ex_fwd_i   = '0;
        ma_fwd_i   = '0;
        wb_fwd_i   = '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;

        run_test("reset", T_RESET, N_RESET);
        run_test("alu", T_ALU, N_TEST);
        run_test("bypass", T_BYPASS, N_TEST);
        run_test("hazard", T_HAZARD, N_TEST);
        run_test("jump", T_JUMP, N_TEST);
        run_test("load_store", T_MEM, N_TEST);

        errors += DUT.u_props.failures;  // bound property failures
        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* verif/decode_props.sv */
`timescale 1ns/1ps

module decode_props (
    input logic               clk_i,
    input logic               rst_n_i,
    input logic               in_valid_i,
    input decode_pkg::word_t  ir_i,
    input logic               ready_i,
    input decode_pkg::jump_t  jump_i,
    input decode_pkg::issue_t issue_i
);

    import decode_pkg::*;

    int   failures = 0;
    logic uses_rs1;
    logic rs1_pending;

    // everything but lui, auipc, jal and unknown opcodes reads rs1
    assign uses_rs1 = ir_i[6:0] inside {OPC_OP, OPC_OP_IMM, OPC_JALR, OPC_BRANCH,
                                        OPC_LOAD, OPC_STORE};

    // issue register result not computed yet
    assign rs1_pending = in_valid_i && !jump_i.valid && uses_rs1 && issue_i.wb_valid
                      && !issue_i.wb_ready && issue_i.wb_addr == ir_i[19:15];

    a_stall_on_hazard: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rs1_pending |-> !ready_i)
        else begin
            failures++;
            $error("ready_o high while rs1 waits on the issue register");
        end

    a_single_jump: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        jump_i.valid |=> !jump_i.valid)
        else begin
            failures++;
            $error("jump_o valid in two cycles in a row");
        end

    // instruction behind a taken jump never issues
    a_bubble_after_jump: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        jump_i.valid |=> !issue_i.valid)
        else begin
            failures++;
            $error("issue_o valid in the cycle after a jump");
        end

endmodule

bind decode_stage decode_props u_props (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .in_valid_i (in_valid_i),
    .ir_i       (ir_i),
    .ready_i    (ready_o),
    .jump_i     (jump_o),
    .issue_i    (issue_o)
);

/* design/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              in_valid_i,
    input  decode_pkg::word_t pc_i,
    input  decode_pkg::word_t ir_i,
    output logic              ready_o,
    input  decode_pkg::fwd_t  ex_fwd_i,
    input  decode_pkg::fwd_t  ma_fwd_i,
    input  decode_pkg::fwd_t  wb_fwd_i,
    output decode_pkg::issue_t issue_o,
    output decode_pkg::jump_t  jump_o
);

    import decode_pkg::*;

    fields_t fields;
    ctrl_t   ctrl;
    word_t   rf_a;
    word_t   rf_b;
    word_t   ra;     // bypassed rs1
    word_t   rb;     // bypassed rs2
    word_t   pc4;
    fwd_t    id_fwd;
    logic    raw_hazard;
    logic    hazard;
    logic    squash;
    logic    active;
    issue_t  issue_d;

    // instruction after a taken jump is dropped
    assign squash = jump_o.valid;
    assign active = in_valid_i && !squash;
    assign hazard = raw_hazard && active;
    assign ready_o = !hazard;

    instr_decoder u_decoder (
        .ir_i     (ir_i),
        .fields_o (fields),
        .ctrl_o   (ctrl)
    );

    regfile u_regfile (
        .clk_i (clk_i),
        .rs1_i (fields.rs1),
        .rs2_i (fields.rs2),
        .ra_o  (rf_a),
        .rb_o  (rf_b),
        .wr_i  (wb_fwd_i)
    );

    // own issue register acts as the youngest forwarding source
    always_comb begin
        id_fwd.valid = issue_o.wb_valid;  // bubbles carry wb_valid low
        id_fwd.ready = issue_o.wb_ready;
        id_fwd.addr  = issue_o.wb_addr;
        id_fwd.data  = issue_o.wb_data;
    end

    operand_bypass u_bypass (
        .rs1_i     (fields.rs1),
        .rs2_i     (fields.rs2),
        .ra_used_i (ctrl.ra_used),
        .rb_used_i (ctrl.rb_used),
        .ra_i      (rf_a),
        .rb_i      (rf_b),
        .id_fwd_i  (id_fwd),
        .ex_fwd_i  (ex_fwd_i),
        .ma_fwd_i  (ma_fwd_i),
        .wb_fwd_i  (wb_fwd_i),
        .ra_o      (ra),
        .rb_o      (rb),
        .hazard_o  (raw_hazard)
    );

    branch_unit u_branch (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .active_i  (active),
        .pc_mode_i (ctrl.pc_mode),
        .funct3_i  (fields.funct3),
        .pc_i      (pc_i),
        .ra_i      (ra),
        .rb_i      (rb),
        .fields_i  (fields),
        .hazard_i  (hazard),
        .jump_o    (jump_o)
    );

    assign pc4 = pc_i + 32'd4;

    always_comb begin
        issue_d.valid = 1'b1;
        issue_d.pc    = pc_i;
        issue_d.ir    = ir_i;

        unique case (ctrl.op1_sel)
            OP1_RS1:  issue_d.alu_op1 = ra;
            OP1_IMMU: issue_d.alu_op1 = fields.imm_u;
            default:  issue_d.alu_op1 = '0;
        endcase

        unique case (ctrl.op2_sel)
            OP2_RS2:  issue_d.alu_op2 = rb;
            OP2_IMMI: issue_d.alu_op2 = fields.imm_i;
            OP2_IMMS: issue_d.alu_op2 = fields.imm_s;
            OP2_PC:   issue_d.alu_op2 = pc_i;
            default:  issue_d.alu_op2 = '0;
        endcase

        issue_d.alu_mode = ctrl.alu_mode;
        issue_d.ma_mode  = ctrl.ma_mode;
        issue_d.ma_size  = ctrl.ma_size;
        issue_d.ma_data  = rb;        // store data
        issue_d.wb_src   = ctrl.wb_src;
        issue_d.wb_addr  = fields.rd;
        issue_d.wb_data  = pc4;       // link value, only final for jal/jalr
        issue_d.wb_ready = (ctrl.wb_src == WB_PC4);
        issue_d.wb_valid = ctrl.wb_valid;
    end

    pipe_reg #(.payload_t(issue_t)) u_issue_reg (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .load_i   (active && !hazard),
        .d_i      (issue_d),
        .bubble_i (NOP_ISSUE),
        .q_o      (issue_o)
    );

endmodule

/* design/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                active_i,  // valid and not squashed
    input  decode_pkg::pc_mode_t pc_mode_i,
    input  logic [2:0]          funct3_i,
    input  decode_pkg::word_t   pc_i,
    input  decode_pkg::word_t   ra_i,
    input  decode_pkg::word_t   rb_i,
    input  decode_pkg::fields_t fields_i,
    input  logic                hazard_i,
    output decode_pkg::jump_t   jump_o
);

    import decode_pkg::*;

    logic  cond;
    logic  take;
    jump_t next_jump;

    localparam jump_t NO_JUMP = '{valid: 1'b0, addr: '0};

    always_comb begin
        unique case ({funct3_i[2:1], 1'b0})
            F3_BEQ:  cond = (ra_i == rb_i);
            F3_BLT:  cond = ($signed(ra_i) < $signed(rb_i));
            F3_BLTU: cond = (ra_i < rb_i);
            default: cond = 1'b0;
        endcase
        cond = cond ^ funct3_i[0];  // bne, bge, bgeu

        next_jump.valid = 1'b1;
        unique case (pc_mode_i)
            PC_JUMP_REL: begin
                take           = 1'b1;
                next_jump.addr = pc_i + fields_i.imm_j;
            end
            PC_JUMP_ABS: begin
                take           = !hazard_i;  // rs1 may not be ready yet
                next_jump.addr = ra_i + fields_i.imm_i;
            end
            PC_BRANCH: begin
                take           = cond && !hazard_i;
                next_jump.addr = pc_i + fields_i.imm_b;
            end
            default: begin
                take           = 1'b0;
                next_jump.addr = '0;
            end
        endcase
    end

    pipe_reg #(.payload_t(jump_t)) u_jump_reg (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .load_i   (active_i && take),
        .d_i      (next_jump),
        .bubble_i (NO_JUMP),
        .q_o      (jump_o)
    );

endmodule

/* design/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass (
    input  decode_pkg::regaddr_t rs1_i,
    input  decode_pkg::regaddr_t rs2_i,
    input  logic                 ra_used_i,
    input  logic                 rb_used_i,
    input  decode_pkg::word_t    ra_i,
    input  decode_pkg::word_t    rb_i,
    input  decode_pkg::fwd_t     id_fwd_i,
    input  decode_pkg::fwd_t     ex_fwd_i,
    input  decode_pkg::fwd_t     ma_fwd_i,
    input  decode_pkg::fwd_t     wb_fwd_i,
    output decode_pkg::word_t    ra_o,
    output decode_pkg::word_t    rb_o,
    output logic                 hazard_o
);

    import decode_pkg::*;

    logic ra_blocked;
    logic rb_blocked;

    function automatic logic hit(input fwd_t src, input regaddr_t addr);
        hit = src.valid && src.addr == addr;
    endfunction

    // youngest producer wins
    function automatic word_t pick(input regaddr_t addr, input word_t rf_val);
        if (hit(id_fwd_i, addr)) begin
            pick = id_fwd_i.data;
        end else if (hit(ex_fwd_i, addr)) begin
            pick = ex_fwd_i.data;
        end else if (hit(ma_fwd_i, addr)) begin
            pick = ma_fwd_i.data;
        end else if (hit(wb_fwd_i, addr)) begin
            pick = wb_fwd_i.data;  // regfile write lands only at the edge
        end else begin
            pick = rf_val;
        end
    endfunction

    // value not computed yet somewhere ahead of wb
    function automatic logic pending(input regaddr_t addr);
        pending = (hit(id_fwd_i, addr) && !id_fwd_i.ready)
               || (hit(ex_fwd_i, addr) && !ex_fwd_i.ready)
               || (hit(ma_fwd_i, addr) && !ma_fwd_i.ready);
    endfunction

    always_comb begin
        ra_o       = pick(rs1_i, ra_i);
        rb_o       = pick(rs2_i, rb_i);
        ra_blocked = ra_used_i && pending(rs1_i);
        rb_blocked = rb_used_i && pending(rs2_i);
        hazard_o   = ra_blocked || rb_blocked;
    end

endmodule

/* design/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
    input  decode_pkg::word_t   ir_i,
    output decode_pkg::fields_t fields_o,
    output decode_pkg::ctrl_t   ctrl_o
);

    import decode_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;  // funct7 bit 5, selects sub and sra

    function automatic alu_mode_t alu_of(input logic [2:0] f3, input logic sub_sra);
        unique case (f3)
            F3_ADD_SUB: alu_of = sub_sra ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_of = ALU_SLL;
            F3_SLT:     alu_of = ALU_SLT;
            F3_SLTU:    alu_of = ALU_SLTU;
            F3_XOR:     alu_of = ALU_XOR;
            F3_SRL_SRA: alu_of = sub_sra ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_of = ALU_OR;
            F3_AND:     alu_of = ALU_AND;
        endcase
    endfunction

    always_comb begin
        opcode = ir_i[6:0];
        funct3 = ir_i[14:12];
        alt    = ir_i[30];

        fields_o.rs1    = ir_i[19:15];
        fields_o.rs2    = ir_i[24:20];
        fields_o.rd     = ir_i[11:7];
        fields_o.funct3 = funct3;
        fields_o.imm_i  = {{20{ir_i[31]}}, ir_i[31:20]};
        fields_o.imm_s  = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
        fields_o.imm_b  = {{19{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
        fields_o.imm_u  = {ir_i[31:12], 12'b0};
        fields_o.imm_j  = {{11{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};
    end

    always_comb begin
        // unknown opcodes fall out as a nop
        ctrl_o = '{op1_sel: OP1_ZERO, op2_sel: OP2_ZERO, alu_mode: ALU_ADD,
                   ma_mode: MA_NONE, ma_size: '0, wb_src: WB_ALU, wb_valid: 1'b0,
                   ra_used: 1'b0, rb_used: 1'b0, pc_mode: PC_NEXT};

        unique case (opcode)
            OPC_OP: begin
                ctrl_o.op1_sel  = OP1_RS1;
                ctrl_o.op2_sel  = OP2_RS2;
                ctrl_o.alu_mode = alu_of(funct3, alt);
                ctrl_o.ra_used  = 1'b1;
                ctrl_o.rb_used  = 1'b1;
                ctrl_o.wb_valid = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl_o.op1_sel  = OP1_RS1;
                ctrl_o.op2_sel  = OP2_IMMI;
                ctrl_o.alu_mode = alu_of(funct3, alt && funct3 == F3_SRL_SRA);  // no subi
                ctrl_o.ra_used  = 1'b1;
                ctrl_o.wb_valid = 1'b1;
            end
            OPC_LUI: begin
                ctrl_o.op1_sel  = OP1_IMMU;
                ctrl_o.wb_valid = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl_o.op1_sel  = OP1_IMMU;
                ctrl_o.op2_sel  = OP2_PC;
                ctrl_o.wb_valid = 1'b1;
            end
            OPC_JAL: begin
                ctrl_o.wb_src   = WB_PC4;
                ctrl_o.wb_valid = 1'b1;
                ctrl_o.pc_mode  = PC_JUMP_REL;
            end
            OPC_JALR: begin
                ctrl_o.ra_used  = 1'b1;
                ctrl_o.wb_src   = WB_PC4;
                ctrl_o.wb_valid = 1'b1;
                ctrl_o.pc_mode  = PC_JUMP_ABS;
            end
            OPC_BRANCH: begin
                ctrl_o.ra_used = 1'b1;
                ctrl_o.rb_used = 1'b1;
                ctrl_o.pc_mode = PC_BRANCH;
            end
            OPC_LOAD: begin
                ctrl_o.op1_sel  = OP1_RS1;
                ctrl_o.op2_sel  = OP2_IMMI;  // address = rs1 + imm_i
                ctrl_o.ma_mode  = MA_LOAD;
                ctrl_o.ma_size  = funct3;
                ctrl_o.ra_used  = 1'b1;
                ctrl_o.wb_src   = WB_MEM;
                ctrl_o.wb_valid = 1'b1;
            end
            OPC_STORE: begin
                ctrl_o.op1_sel = OP1_RS1;
                ctrl_o.op2_sel = OP2_IMMS;
                ctrl_o.ma_mode = MA_STORE;
                ctrl_o.ma_size = funct3;
                ctrl_o.ra_used = 1'b1;
                ctrl_o.rb_used = 1'b1;  // store data
            end
            default: ;
        endcase
    end

endmodule

/* design/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                clk_i,
    input  decode_pkg::regaddr_t rs1_i,
    input  decode_pkg::regaddr_t rs2_i,
    output decode_pkg::word_t    ra_o,
    output decode_pkg::word_t    rb_o,
    input  decode_pkg::fwd_t     wr_i
);

    import decode_pkg::*;

    word_t regs [1:31];  // x0 has no storage

    // reads are asynchronous, old value during a write cycle
    always_comb begin
        ra_o = (rs1_i == '0) ? '0 : regs[rs1_i];
        rb_o = (rs2_i == '0) ? '0 : regs[rs2_i];
    end

    always_ff @(posedge clk_i) begin
        if (wr_i.valid && wr_i.addr != '0) begin
            regs[wr_i.addr] <= wr_i.data;  // ready is not looked at here
        end
    end

endmodule

/* design/pipe_reg.sv */
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     load_i,
    input  payload_t d_i,
    input  payload_t bubble_i,
    output payload_t q_o
);

    // bubble on reset or whenever nothing is loaded
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            q_o <= bubble_i;
        end else if (load_i) begin
            q_o <= d_i;
        end else begin
            q_o <= bubble_i;
        end
    end

endmodule

/* design/decode_pkg.sv */
package decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regaddr_t;
    typedef logic [2:0]  ma_size_t;  // funct3 of a load or store

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_mode_t;

    typedef enum logic [1:0] {MA_NONE, MA_LOAD, MA_STORE} ma_mode_t;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_src_t;
    typedef enum logic [1:0] {OP1_ZERO, OP1_RS1, OP1_IMMU} op1_sel_t;
    typedef enum logic [2:0] {OP2_ZERO, OP2_RS2, OP2_IMMI, OP2_IMMS, OP2_PC} op2_sel_t;
    typedef enum logic [1:0] {PC_NEXT, PC_JUMP_REL, PC_JUMP_ABS, PC_BRANCH} pc_mode_t;

    typedef struct packed {
        op1_sel_t  op1_sel;
        op2_sel_t  op2_sel;
        alu_mode_t alu_mode;
        ma_mode_t  ma_mode;
        ma_size_t  ma_size;
        wb_src_t   wb_src;
        logic      wb_valid;
        logic      ra_used;
        logic      rb_used;
        pc_mode_t  pc_mode;
    } ctrl_t;

    typedef struct packed {
        regaddr_t   rs1;
        regaddr_t   rs2;
        regaddr_t   rd;
        logic [2:0] funct3;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_u;
        word_t      imm_j;
    } fields_t;

    // write-back value offered by a later stage
    typedef struct packed {
        logic     valid;
        logic     ready;  // low while a load is still in flight
        regaddr_t addr;
        word_t    data;
    } fwd_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        word_t     ir;
        word_t     alu_op1;
        word_t     alu_op2;
        alu_mode_t alu_mode;
        ma_mode_t  ma_mode;
        ma_size_t  ma_size;
        word_t     ma_data;
        wb_src_t   wb_src;
        regaddr_t  wb_addr;
        word_t     wb_data;
        logic      wb_ready;
        logic      wb_valid;
    } issue_t;

    typedef struct packed {
        logic  valid;
        word_t addr;
    } jump_t;

    localparam issue_t NOP_ISSUE = '{
        valid: 1'b0, pc: '0, ir: '0, alu_op1: '0, alu_op2: '0,
        alu_mode: ALU_ADD, ma_mode: MA_NONE, ma_size: '0, ma_data: '0,
        wb_src: WB_ALU, wb_addr: '0, wb_data: '0, wb_ready: 1'b0, wb_valid: 1'b0
    };

    // base opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // alu funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3, bit 0 inverts the condition
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

endpackage
